// ==== project.f ====
+incdir+test
hdl/cpu_isa_pkg.sv
hdl/cpu_pipe_pkg.sv
hdl/cpu_fetch.sv
hdl/cpu_decode.sv
hdl/cpu_mul_unit.sv
hdl/cpu_execute.sv
hdl/cpu.sv
test/cpu_tb.sv

// ==== test/cpu_tb_model.svh ====
////////////////////////////////////////////////////////////////////////////
// testbench helpers, included inside the testbench module
// random number source, program generator and ISA reference model
////////////////////////////////////////////////////////////////////////////

`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

localparam int unsigned LCG_SEED = 12;
localparam int PROG_LEN = 48;
// longest forward branch offset
localparam int MAX_SKIP = 15;

logic [31:0] lcg_state = LCG_SEED;
// instruction memory shared with the bus slave
logic [15:0] mem [0:1023];
// expected commit sequence of the current program
cpu_pipe_pkg::commit_packet_t exp_q [$];

// 32-bit LCG, upper bits are the better ones
function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
endfunction

////////////////////////////////////////////////////////////////////////////
// program generator
////////////////////////////////////////////////////////////////////////////
task automatic build_program();
    int unsigned r;
    int span;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    // unused space decodes as HALT, low bits carry the address
    for (int a = 0; a < 1024; a++) begin
        mem[a] = 16'hE000 | 16'(a);
    end
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        r   = next_rand() % 16;
        rd  = 3'(next_rand());
        rs1 = 3'(next_rand());
        rs2 = 3'(next_rand());
        if (r < 6) begin
            // ADD, SUB, AND, XOR with random unused nibble
            mem[i] = {3'(r % 4), rd, rs1, rs2, 4'(next_rand())};
        end else if (r < 10) begin
            mem[i] = {cpu_isa_pkg::OP_ADDI, rd, rs1, 7'(next_rand())};
        end else if (r < 12) begin
            mem[i] = {cpu_isa_pkg::OP_MUL, rd, rs1, rs2, 4'(next_rand())};
        end else begin
            // forward only, target stays inside the program
            span = PROG_LEN - 2 - i;
            if (span > MAX_SKIP) begin
                span = MAX_SKIP;
            end
            mem[i] = {cpu_isa_pkg::OP_BNEZ, rd, rs1, 7'(next_rand() % (span + 1))};
        end
    end
    mem[PROG_LEN - 1] = {cpu_isa_pkg::OP_HALT, 13'd0};
endtask

////////////////////////////////////////////////////////////////////////////
// ISA reference model, one commit per executed instruction
////////////////////////////////////////////////////////////////////////////
task automatic run_model(output bit reached_halt);
    logic [15:0] regs [0:7];
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [9:0]  pc;
    cpu_isa_pkg::opcode_e op;
    cpu_pipe_pkg::commit_packet_t c;
    int steps;
    for (int i = 0; i < 8; i++) begin
        regs[i] = '0;
    end
    exp_q.delete();
    pc    = '0;
    steps = 0;
    c     = '0;
    while (!c.halt && steps < 1024) begin
        w   = mem[pc];
        // field positions of the r and i formats
        op  = cpu_isa_pkg::opcode_e'(w[15:13]);
        a   = regs[w[9:7]];
        b   = regs[w[6:4]];
        imm = {{9{w[6]}}, w[6:0]};
        c          = '0;
        c.valid    = 1'b1;
        c.wr_en    = 1'b1;
        c.wr_idx   = w[12:10];
        c.npc      = pc + 10'd1;
        case (op)
            cpu_isa_pkg::OP_ADD:  c.wr_data = a + b;
            cpu_isa_pkg::OP_SUB:  c.wr_data = a - b;
            cpu_isa_pkg::OP_AND:  c.wr_data = a & b;
            cpu_isa_pkg::OP_XOR:  c.wr_data = a ^ b;
            cpu_isa_pkg::OP_ADDI: c.wr_data = a + imm;
            cpu_isa_pkg::OP_MUL:  c.wr_data = a * b;
            cpu_isa_pkg::OP_BNEZ: begin
                c.wr_en = 1'b0;
                if (a != '0) begin
                    c.npc = pc + 10'd1 + imm[9:0];
                end
            end
            default: begin
                c.wr_en = 1'b0;
                c.halt  = 1'b1;
            end
        endcase
        if (c.wr_en) begin
            regs[c.wr_idx] = c.wr_data;
        end
        exp_q.push_back(c);
        pc = c.npc;
        steps++;
    end
    reached_halt = c.halt;
endtask

`endif

// ==== test/cpu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// runs random programs on the core from a Wishbone memory
// with random wait states and checks each commit against the ISA model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int NUM_PROGS = 3;
    // cycles the core must stay silent after HALT
    localparam int QUIET_CYCLES = 30;
    localparam int TIMEOUT_CYCLES = NUM_PROGS * 48 * (16 + 8) + 600;

    logic clock;
    logic arst_n;
    cpu_pipe_pkg::wb_req_t        imem_req;
    cpu_pipe_pkg::wb_rsp_t        imem_rsp;
    cpu_pipe_pkg::commit_packet_t commit;

    `include "cpu_tb_model.svh"

    // bus slave state
    logic slave_busy;
    int   wait_left;
    // checker state
    cpu_pipe_pkg::commit_packet_t expected;
    int  commit_count;
    int  model_count;
    bit  halt_seen;
    bit  model_ok;
    int  cycle_count;

    cpu u_dut (
        .clock    (clock),
        .arst_n   (arst_n),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .commit   (commit)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h (commit %0d)",
                     $time, what, got, exp, commit_count);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%0t ns: %s", $time, reason);
        $display("ERRORS FOUND");
        $fatal(1, "run aborted");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // wishbone memory slave with 0 to 3 wait states per read
    ////////////////////////////////////////////////////////////////////////
    always @(posedge clock) begin
        #1;
        if (!arst_n) begin
            imem_rsp   = '0;
            slave_busy = 1'b0;
        end else if (imem_rsp.ack) begin
            // master saw ack at this edge
            imem_rsp.ack = 1'b0;
            slave_busy   = 1'b0;
        end else if (imem_req.cyc && imem_req.stb) begin
            if (!slave_busy) begin
                slave_busy = 1'b1;
                wait_left  = next_rand() % 4;
            end
            if (wait_left == 0) begin
                imem_rsp.ack = 1'b1;
                imem_rsp.dat = mem[imem_req.adr];
            end else begin
                wait_left--;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // commit checker sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////
    always @(negedge clock) begin
        if (arst_n && commit.valid) begin
            if (halt_seen) begin
                abort_run("instruction committed after HALT");
            end else begin
                expected = exp_q.pop_front();
                check_value("wr_en", commit.wr_en, expected.wr_en);
                // index and data only mean something on a write
                if (expected.wr_en) begin
                    check_value("wr_idx", commit.wr_idx, expected.wr_idx);
                    check_value("wr_data", commit.wr_data, expected.wr_data);
                end
                check_value("npc", commit.npc, expected.npc);
                check_value("halt", commit.halt, expected.halt);
                commit_count++;
                if (commit.halt) begin
                    halt_seen = 1'b1;
                end
            end
        end
    end

    // global limit over all programs
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core never halted", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clock       = 1'b0;
        arst_n      = 1'b0;
        imem_rsp    = '0;
        slave_busy  = 1'b0;
        wait_left   = 0;
        cycle_count = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            build_program();
            run_model(model_ok);
            if (!model_ok) begin
                abort_run("reference model never reached HALT");
            end
            model_count  = exp_q.size();
            commit_count = 0;
            halt_seen    = 1'b0;
            // reset between programs while the core is idle
            @(posedge clock);
            #1 arst_n = 1'b0;
            repeat (3) @(posedge clock);
            #1 arst_n = 1'b1;
            wait (halt_seen);
            repeat (QUIET_CYCLES) @(posedge clock);
            check_value("commit count", 16'(commit_count), 16'(model_count));
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu.sv ====
////////////////////////////////////////////////////////////////////////////
// top level of the three-stage core
// fetch, decode and execute joined by the fd and de pipeline registers
// instruction memory on a Wishbone port, retired ops on the commit port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire logic                     clock,
    input  wire logic                     arst_n,
    output cpu_pipe_pkg::wb_req_t         imem_req,
    input  wire cpu_pipe_pkg::wb_rsp_t    imem_rsp,
    output cpu_pipe_pkg::commit_packet_t  commit
);

    cpu_pipe_pkg::fetch_packet_t  fetch_packet;
    cpu_pipe_pkg::fetch_packet_t  fd_reg;
    cpu_pipe_pkg::decode_packet_t decode_packet;
    cpu_pipe_pkg::decode_packet_t de_reg;

    // hazard controls from execute
    logic               stall;
    logic               squash;
    cpu_isa_pkg::addr_t redirect_pc;

    ////////////////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////////////////
    cpu_fetch u_fetch (
        .clock        (clock),
        .arst_n       (arst_n),
        .stall        (stall),
        .squash       (squash),
        .redirect_pc  (redirect_pc),
        .imem_req     (imem_req),
        .imem_rsp     (imem_rsp),
        .fetch_packet (fetch_packet)
    );

    // squash wins over stall, both regs frozen while stalled
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fd_reg <= '0;
        end else if (squash) begin
            fd_reg <= '0;
        end else if (!stall) begin
            fd_reg <= fetch_packet;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////
    cpu_decode u_decode (
        .fetch_packet  (fd_reg),
        .decode_packet (decode_packet)
    );

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            de_reg <= '0;
        end else if (squash) begin
            de_reg <= '0;
        end else if (!stall) begin
            de_reg <= decode_packet;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // execute and retire
    ////////////////////////////////////////////////////////////////////////
    cpu_execute u_execute (
        .clock         (clock),
        .arst_n        (arst_n),
        .decode_packet (de_reg),
        .stall         (stall),
        .squash        (squash),
        .redirect_pc   (redirect_pc),
        .commit        (commit)
    );

endmodule

`default_nettype wire

// ==== hdl/cpu_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// execute stage: register file, ALU, branch and multiply sequencing
// every instruction retires here and is reported on the commit port
// drives stall for multiply and halt, squash for a taken BNEZ
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
    input  wire logic                          clock,
    input  wire logic                          arst_n,
    input  wire cpu_pipe_pkg::decode_packet_t  decode_packet,
    output logic                               stall,
    output logic                               squash,
    output cpu_isa_pkg::addr_t                 redirect_pc,
    output cpu_pipe_pkg::commit_packet_t       commit
);

    cpu_isa_pkg::word_t rf [0:7];
    cpu_isa_pkg::word_t op_a;
    cpu_isa_pkg::word_t op_b;
    cpu_isa_pkg::word_t result;
    cpu_isa_pkg::word_t product;
    cpu_isa_pkg::addr_t npc_seq;
    logic halted;
    // multiply issued, waiting for product
    logic mul_pending;
    logic mul_busy;
    logic is_mul;
    logic mul_start;
    logic mul_ready;
    logic fire;
    logic taken;

    ////////////////////////////////////////////////////////////////////////
    // operands and ALU
    ////////////////////////////////////////////////////////////////////////
    // register file read straight away, writes retire in this stage
    assign op_a = rf[decode_packet.rs1];
    assign op_b = decode_packet.uses_rs2 ? rf[decode_packet.rs2] : decode_packet.imm_ext;

    always_comb begin
        case (decode_packet.op)
            cpu_isa_pkg::OP_ADD,
            cpu_isa_pkg::OP_ADDI: result = op_a + op_b;
            cpu_isa_pkg::OP_SUB:  result = op_a - op_b;
            cpu_isa_pkg::OP_AND:  result = op_a & op_b;
            cpu_isa_pkg::OP_XOR:  result = op_a ^ op_b;
            cpu_isa_pkg::OP_MUL:  result = product;
            default:              result = '0;
        endcase
    end

    // branch target, forward offsets only in practice
    assign npc_seq     = decode_packet.pc + 1'b1;
    assign redirect_pc = npc_seq + decode_packet.imm_ext[9:0];
    assign taken       = (decode_packet.op == cpu_isa_pkg::OP_BNEZ) && (op_a != '0);

    ////////////////////////////////////////////////////////////////////////
    // multiply sequencing and retire
    ////////////////////////////////////////////////////////////////////////
    assign is_mul    = decode_packet.valid && !halted &&
                       (decode_packet.op == cpu_isa_pkg::OP_MUL);
    assign mul_start = is_mul && !mul_pending;
    assign mul_ready = is_mul && mul_pending && !mul_busy;

    cpu_mul_unit u_mul (
        .clock   (clock),
        .arst_n  (arst_n),
        .start   (mul_start),
        .a       (op_a),
        .b       (op_b),
        .busy    (mul_busy),
        .product (product)
    );

    // retires this cycle
    assign fire   = decode_packet.valid && !halted && (!is_mul || mul_ready);
    assign stall  = halted || (is_mul && !mul_ready);
    assign squash = fire && taken;

    assign commit.valid   = fire;
    assign commit.wr_en   = fire && decode_packet.writes_rd;
    assign commit.wr_idx  = decode_packet.rd;
    assign commit.wr_data = result;
    assign commit.npc     = taken ? redirect_pc : npc_seq;
    assign commit.halt    = decode_packet.op == cpu_isa_pkg::OP_HALT;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            halted      <= 1'b0;
            mul_pending <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (mul_start) begin
                mul_pending <= 1'b1;
            end else if (mul_ready) begin
                mul_pending <= 1'b0;
            end
            // stays halted until reset
            if (fire && commit.halt) begin
                halted <= 1'b1;
            end
            if (commit.wr_en) begin
                rf[decode_packet.rd] <= result;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_mul_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// iterative shift-add multiplier, low 16 bits of the product
// bit 0 is taken on start, the other 15 bits on the following cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_mul_unit (
    input  wire logic                clock,
    input  wire logic                arst_n,
    input  wire logic                start,
    input  wire cpu_isa_pkg::word_t  a,
    input  wire cpu_isa_pkg::word_t  b,
    output logic                     busy,
    output cpu_isa_pkg::word_t       product
);

    // remaining iterations after start
    logic [3:0]         count;
    cpu_isa_pkg::word_t acc;
    cpu_isa_pkg::word_t mcand;
    cpu_isa_pkg::word_t mplier;

    // control
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= 4'd15;
        end else if (busy) begin
            count <= count - 1'b1;
            // last bit retires here
            if (count == 4'd1) begin
                busy <= 1'b0;
            end
        end
    end

    // datapath
    always_ff @(posedge clock) begin
        if (start) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
        end else if (busy) begin
            acc    <= mplier[0] ? acc + mcand : acc;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== hdl/cpu_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// purely combinational decode stage
// splits the instruction word into register indices and control bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  wire cpu_pipe_pkg::fetch_packet_t  fetch_packet,
    output cpu_pipe_pkg::decode_packet_t      decode_packet
);

    // opcode sits in the same bits in both formats
    cpu_isa_pkg::opcode_e op;
    logic                 imm_fmt;

    assign op      = fetch_packet.instr.r.op;
    assign imm_fmt = (op == cpu_isa_pkg::OP_ADDI) || (op == cpu_isa_pkg::OP_BNEZ);

    always_comb begin
        decode_packet       = '0;
        decode_packet.valid = fetch_packet.valid;
        decode_packet.pc    = fetch_packet.pc;
        decode_packet.op    = op;
        // rd and rs1 share their bits in both formats
        decode_packet.rd    = fetch_packet.instr.r.rd;
        decode_packet.rs1   = fetch_packet.instr.r.rs1;

        if (imm_fmt) begin
            // rs2 slot carries immediate bits in the i-format
            decode_packet.imm_ext = {{9{fetch_packet.instr.i.imm[6]}},
                                     fetch_packet.instr.i.imm};
        end else begin
            decode_packet.rs2 = fetch_packet.instr.r.rs2;
        end

        // second register operand only for reg-reg ops
        case (op)
            cpu_isa_pkg::OP_ADD,
            cpu_isa_pkg::OP_SUB,
            cpu_isa_pkg::OP_AND,
            cpu_isa_pkg::OP_XOR,
            cpu_isa_pkg::OP_MUL: decode_packet.uses_rs2 = 1'b1;
            default:             decode_packet.uses_rs2 = 1'b0;
        endcase

        // neither BNEZ nor HALT writes rd
        decode_packet.writes_rd = (op != cpu_isa_pkg::OP_BNEZ) &&
                                  (op != cpu_isa_pkg::OP_HALT);
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_fetch.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch stage: program counter and one Wishbone read at a time
// the fetched word is held as a packet until the pipeline takes it
// squash from execute redirects the pc and drops any stale response
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cpu_fetch (
    input  wire logic                        clock,
    input  wire logic                        arst_n,
    input  wire logic                        stall,
    input  wire logic                        squash,
    input  wire cpu_isa_pkg::addr_t          redirect_pc,
    output cpu_pipe_pkg::wb_req_t            imem_req,
    input  wire cpu_pipe_pkg::wb_rsp_t       imem_rsp,
    output cpu_pipe_pkg::fetch_packet_t      fetch_packet
);

    // next address to fetch
    cpu_isa_pkg::addr_t pc;
    // registered bus request, cyc doubles as the bus-active flag
    cpu_pipe_pkg::wb_req_t req_q;
    // response of the current cycle belongs to a squashed path
    logic drop;
    cpu_pipe_pkg::fetch_packet_t pkt;
    // held packet moves into fd_reg at this edge
    logic taken;

    assign taken = pkt.valid && !stall;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= cpu_pipe_pkg::RESET_PC;
            req_q <= '0;
            drop  <= 1'b0;
            pkt   <= '0;
        end else begin
            // packet leaves on hand-off or is killed by squash
            if (squash || taken) begin
                pkt.valid <= 1'b0;
            end
            if (squash) begin
                pc <= redirect_pc;
            end

            ////////////////////////////////////////////////////////////////////
            // bus cycle
            ////////////////////////////////////////////////////////////////////
            if (req_q.cyc) begin
                if (imem_rsp.ack) begin
                    // end of cycle, cyc and stb drop next
                    req_q.cyc <= 1'b0;
                    req_q.stb <= 1'b0;
                    drop      <= 1'b0;
                    if (!drop && !squash) begin
                        pkt.valid <= 1'b1;
                        pkt.pc    <= req_q.adr;
                        pkt.instr <= imem_rsp.dat;
                        pc        <= pc + 1'b1;
                    end
                end else if (squash) begin
                    // address must stay on the bus, so mark the data stale
                    drop <= 1'b1;
                end
            end else if (!squash && (!pkt.valid || !stall)) begin
                // slot is free or empties at this edge
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
                req_q.adr <= pc;
            end
        end
    end

    assign imem_req     = req_q;
    assign fetch_packet = pkt;

endmodule

`default_nettype wire

// ==== hdl/cpu_pipe_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// microarchitecture types of the core
// stage packets, the commit record and the Wishbone instruction port
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cpu_pipe_pkg;

    // first fetch address out of reset
    localparam cpu_isa_pkg::addr_t RESET_PC = '0;

    // fetch -> decode, held by fetch until taken
    typedef struct packed {
        logic                valid;
        cpu_isa_pkg::addr_t  pc;
        cpu_isa_pkg::instr_u instr;
    } fetch_packet_t;

    // decode -> execute, fields already pulled out of the word
    typedef struct packed {
        logic                 valid;
        cpu_isa_pkg::addr_t   pc;
        cpu_isa_pkg::opcode_e op;
        cpu_isa_pkg::reg_idx_t rd;
        cpu_isa_pkg::reg_idx_t rs1;
        cpu_isa_pkg::reg_idx_t rs2;
        // sign-extended 7-bit immediate
        cpu_isa_pkg::word_t   imm_ext;
        logic                 uses_rs2;
        logic                 writes_rd;
    } decode_packet_t;

    // one retired instruction
    typedef struct packed {
        logic                  valid;
        logic                  wr_en;
        cpu_isa_pkg::reg_idx_t wr_idx;
        cpu_isa_pkg::word_t    wr_data;
        cpu_isa_pkg::addr_t    npc;
        logic                  halt;
    } commit_packet_t;

    // wishbone classic, read-only master side
    typedef struct packed {
        logic               cyc;
        logic               stb;
        cpu_isa_pkg::addr_t adr;
    } wb_req_t;

    typedef struct packed {
        logic               ack;
        cpu_isa_pkg::word_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_isa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction set of the 16-bit teaching core
// word and index types, opcodes and the two instruction formats
// referenced by scoped name from the pipeline package and every stage
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package cpu_isa_pkg;

    // data path and register file widths
    localparam int unsigned WORD_W = 16;
    localparam int unsigned REG_W  = 3;
    localparam int unsigned ADDR_W = 10;
    localparam int unsigned IMM_W  = 7;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    // word address into instruction memory
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADDI = 3'd4,
        OP_MUL  = 3'd5,
        OP_BNEZ = 3'd6,
        OP_HALT = 3'd7
    } opcode_e;

    // register-register format, low nibble unused
    typedef struct packed {
        opcode_e     op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [3:0]  unused;
    } r_fmt_t;

    // immediate format for ADDI and BNEZ
    typedef struct packed {
        opcode_e                  op;
        reg_idx_t                 rd;
        reg_idx_t                 rs1;
        logic signed [IMM_W-1:0]  imm;
    } i_fmt_t;

    // one fetched word, read through whichever format the opcode picks
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire
